// ==== sources.f ====
design/icmp_pkg.sv
design/icmp_rx.sv
design/icmp_pld_buf.sv
design/icmp_echo_ctrl.sv
design/icmp_tx.sv
design/icmp_echo_top.sv
verif/icmp_echo_props.sv
verif/icmp_echo_tb.sv

// ==== verif/icmp_echo_tb.sv ====
`timescale 1ns/100ps

module icmp_echo_tb;

  import icmp_pkg::*;

  localparam int MAX_PLD = 64;
  localparam int NROWS   = 13;

  // Lengths count the ICMP header plus payload
  typedef struct packed {
    logic [7:0]  proto;
    logic [7:0]  typ;
    logic [7:0]  code;
    logic [15:0] nbytes;   // Bytes actually sent
    logic [15:0] decl;     // pld_len in the metadata
    logic        inj_err;
    logic        overlap;  // Sent while the previous reply runs
    logic        reply;    // A reply must come out
  } row_t;

  logic       clk;
  logic       fsm_rst;
  stream_t    in_strm;
  ipv4_meta_t in_meta;
  stream_t    out_strm;
  ipv4_meta_t out_meta;
  logic       busy;

  row_t       rows [0:NROWS-1];
  integer     seed;
  int         cyc = 0;
  int         limit = 0;
  int         pending = 0;     // Replies expected but not finished
  logic       drv_reply;       // Current input frame should be answered

  logic [7:0] exp_bytes [$];
  int         exp_len [$];
  ipv4_meta_t exp_meta [$];
  int         eof_cyc [$];     // Input eof times of answered requests

  logic       in_frame = 1'b0;
  int         idx = 0;
  int         cur_len = 0;
  ipv4_meta_t cur_meta;
  int         after_eof = 0;
  logic [2:0] busy_hist = 3'b000;  // Busy at the last three negedges

  icmp_echo_top #(
    .MAX_PLD (MAX_PLD)
  ) i_icmp_echo_top (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .in_strm  (in_strm),
    .in_meta  (in_meta),
    .out_strm (out_strm),
    .out_meta (out_meta),
    .busy     (busy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      $display("** Error @ %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  // Ones' complement 16-bit add with the carry wrapped around
  function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
    logic [16:0] s;
    s = a + b;
    return s[15:0] + {15'd0, s[16]};
  endfunction

  task automatic load_table();
    rows[0]  = '{8'd1, 8'd8, 8'd0, 16'd24, 16'd24, 1'b0, 1'b0, 1'b1};  // Plain request
    rows[1]  = '{8'd6, 8'd8, 8'd0, 16'd20, 16'd20, 1'b0, 1'b0, 1'b0};  // TCP
    rows[2]  = '{8'd1, 8'd0, 8'd0, 16'd20, 16'd20, 1'b0, 1'b0, 1'b0};  // Echo reply in
    rows[3]  = '{8'd1, 8'd3, 8'd0, 16'd20, 16'd20, 1'b0, 1'b0, 1'b0};  // Unreachable
    rows[4]  = '{8'd1, 8'd8, 8'd1, 16'd20, 16'd20, 1'b0, 1'b0, 1'b0};  // Nonzero code
    rows[5]  = '{8'd1, 8'd8, 8'd0, 16'd20, 16'd24, 1'b0, 1'b0, 1'b0};  // Short frame
    rows[6]  = '{8'd1, 8'd8, 8'd0, 16'd16, 16'd16, 1'b1, 1'b0, 1'b0};  // Err beat
    rows[7]  = '{8'd1, 8'd8, 8'd0, 16'd78, 16'd78, 1'b0, 1'b0, 1'b0};  // Too long
    rows[8]  = '{8'd1, 8'd8, 8'd0, 16'd8,  16'd8,  1'b0, 1'b0, 1'b1};  // Header only
    rows[9]  = '{8'd1, 8'd8, 8'd0, 16'd72, 16'd72, 1'b0, 1'b0, 1'b1};  // Full buffer
    rows[10] = '{8'd1, 8'd8, 8'd0, 16'd30, 16'd30, 1'b0, 1'b1, 1'b0};  // Hits busy
    rows[11] = '{8'd1, 8'd8, 8'd0, 16'd40, 16'd40, 1'b0, 1'b0, 1'b1};
    rows[12] = '{8'd1, 8'd8, 8'd0, 16'd9,  16'd9,  1'b0, 1'b0, 1'b1};
  endtask

  task automatic send_frame(input row_t row);
    logic [15:0] cks;
    logic [15:0] id;
    logic [15:0] seq;
    logic [31:0] src;
    logic [31:0] dst;
    logic [7:0]  frm [0:127];
    ipv4_meta_t  meta;
    ipv4_meta_t  rsp_meta;
    int          i;
    cks = $random(seed);
    id  = $random(seed);
    seq = $random(seed);
    src = $random(seed);
    dst = $random(seed);
    frm[0] = row.typ;
    frm[1] = row.code;
    {frm[2], frm[3]} = cks;
    {frm[4], frm[5]} = id;
    {frm[6], frm[7]} = seq;
    for (i = 8; i < row.nbytes; i++) frm[i] = $random(seed);
    meta = '{src_ip: src, dst_ip: dst, proto: row.proto, pld_len: row.decl};
    if (row.reply) begin
      rsp_meta = '{src_ip: dst, dst_ip: src, proto: 8'd1, pld_len: row.decl};
      exp_meta.push_back(rsp_meta);
      exp_len.push_back(row.nbytes);
      frm[0] = 8'h00;                         // Reply type
      {frm[2], frm[3]} = ones_add(cks, 16'h0800);
      for (i = 0; i < row.nbytes; i++) exp_bytes.push_back(frm[i]);
      frm[0] = row.typ;
      {frm[2], frm[3]} = cks;
      pending++;
    end
    for (i = 0; i < row.nbytes; i++) begin
      @(posedge clk);
      in_strm   <= '{dat: frm[i], val: 1'b1, sof: (i == 0), eof: (i == row.nbytes - 1),
                     err: row.inj_err && (i == row.nbytes / 2)};
      in_meta   <= meta;
      drv_reply <= row.reply;
    end
    @(posedge clk);
    in_strm   <= '0;
    drv_reply <= 1'b0;
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (limit != 0 && cyc >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

  // Output monitor, samples in the middle of the cycle
  always @(negedge clk) begin
    if (in_strm.val && in_strm.eof && drv_reply) eof_cyc.push_back(cyc);
    if (after_eof == 1) begin
      check(busy, 1'b0, "busy one cycle after out eof");
      after_eof = 0;
    end
    if (out_strm.val) begin
      if (out_strm.sof) begin
        check(in_frame, 1'b0, "out sof inside a frame");
        check(exp_len.size() != 0, 1'b1, "reply without a pending request");
        cur_len  = exp_len.pop_front();
        cur_meta = exp_meta.pop_front();
        check(cyc - eof_cyc.pop_front(), 4, "input eof to output sof latency");
        check(busy_hist, 3'b011, "busy history before out sof");
        in_frame = 1'b1;
        idx      = 0;
      end
      check(in_frame, 1'b1, "out beat outside a frame");
      check(out_strm.dat, exp_bytes.pop_front(), $sformatf("reply byte %0d", idx));
      check(out_strm.eof, idx == cur_len - 1, "out eof position");
      check(out_strm.err, 1'b0, "out err");
      check(out_meta, cur_meta, "reply metadata");
      if (out_strm.eof) begin
        check(busy, 1'b1, "busy at out eof");
        in_frame  = 1'b0;
        after_eof = 1;
        pending--;
      end
      idx++;
    end else if (in_frame) begin
      check(out_strm.val, 1'b1, "gap inside reply frame");
    end
    busy_hist = {busy_hist[1:0], busy};
  end

  initial begin : main
    int r;
    fsm_rst   = 1'b1;
    in_strm   = '0;
    in_meta   = '0;
    drv_reply = 1'b0;
    seed      = 32'h30bf_9d9d;
    load_table();
    for (r = 0; r < NROWS; r++) begin
      limit += rows[r].nbytes + 20;
    end
    repeat (4) @(posedge clk);
    fsm_rst <= 1'b0;
    for (r = 0; r < NROWS; r++) begin
      if (rows[r].overlap) begin
        while (!busy) @(posedge clk);
      end else begin
        while (pending != 0 || busy) @(posedge clk);
        repeat (2) @(posedge clk);
      end
      send_frame(rows[r]);
    end
    while (pending != 0 || busy) @(posedge clk);
    repeat (10) @(posedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule : icmp_echo_tb

// ==== verif/icmp_echo_props.sv ====
`timescale 1ns/100ps

module icmp_echo_props (
  input logic              clk,
  input logic              fsm_rst,
  input icmp_pkg::stream_t out_strm,
  input logic              busy
);

  logic in_frame;  // Between out sof and out eof

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      in_frame <= 1'b0;
    end else if (out_strm.val && out_strm.eof) begin
      in_frame <= 1'b0;
    end else if (out_strm.val && out_strm.sof) begin
      in_frame <= 1'b1;
    end
  end

  a_strobe_val : assert property (@(posedge clk) disable iff (fsm_rst)
    (out_strm.sof || out_strm.eof) |-> out_strm.val)
    else $error("out sof or eof without val");

  a_busy_rst : assert property (@(posedge clk) fsm_rst |=> !busy)
    else $error("busy high in the cycle after reset");

  a_one_sof : assert property (@(posedge clk) disable iff (fsm_rst)
    (out_strm.val && out_strm.sof) |-> !in_frame)
    else $error("second out sof before out eof");

  a_busy_val : assert property (@(posedge clk) disable iff (fsm_rst)
    out_strm.val |-> busy)
    else $error("out val while busy is low");

endmodule : icmp_echo_props

bind icmp_echo_top icmp_echo_props i_icmp_echo_props (
  .clk      (clk),
  .fsm_rst  (fsm_rst),
  .out_strm (out_strm),
  .busy     (busy)
);

// ==== design/icmp_echo_top.sv ====
`timescale 1ns/100ps

module icmp_echo_top #(
  parameter int MAX_PLD = 64
) (
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  icmp_pkg::stream_t    in_strm,
  input  icmp_pkg::ipv4_meta_t in_meta,
  output icmp_pkg::stream_t    out_strm,
  output icmp_pkg::ipv4_meta_t out_meta,
  output logic                 busy
);

  import icmp_pkg::*;

  localparam int AW = $clog2(MAX_PLD);

  logic          wr_en;
  logic [AW-1:0] wr_addr;
  logic [7:0]    wr_dat;
  logic [AW-1:0] rd_addr;
  logic [7:0]    rd_dat;
  logic          req_val;
  echo_req_t     req;
  logic          start;
  echo_rsp_t     rsp;
  logic          done;

  icmp_rx #(
    .MAX_PLD (MAX_PLD)
  ) i_icmp_rx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .busy    (busy),
    .in_strm (in_strm),
    .in_meta (in_meta),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_dat  (wr_dat),
    .req_val (req_val),
    .req     (req)
  );

  icmp_pld_buf #(
    .MAX_PLD (MAX_PLD)
  ) i_icmp_pld_buf (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_dat  (wr_dat),
    .rd_addr (rd_addr),
    .rd_dat  (rd_dat)
  );

  icmp_echo_ctrl i_icmp_echo_ctrl (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .req_val (req_val),
    .req     (req),
    .done    (done),
    .busy    (busy),
    .start   (start),
    .rsp     (rsp)
  );

  icmp_tx #(
    .MAX_PLD (MAX_PLD)
  ) i_icmp_tx (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .start    (start),
    .rsp      (rsp),
    .rd_addr  (rd_addr),
    .rd_dat   (rd_dat),
    .out_strm (out_strm),
    .out_meta (out_meta),
    .done     (done)
  );

endmodule : icmp_echo_top

// ==== design/icmp_tx.sv ====
`timescale 1ns/100ps

module icmp_tx #(
  parameter int MAX_PLD = 64
) (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       start,
  input  icmp_pkg::echo_rsp_t        rsp,
  output logic [$clog2(MAX_PLD)-1:0] rd_addr,
  input  logic [7:0]                 rd_dat,
  output icmp_pkg::stream_t          out_strm,
  output icmp_pkg::ipv4_meta_t       out_meta,
  output logic                       done
);

  import icmp_pkg::*;

  localparam int          AW      = $clog2(MAX_PLD);
  localparam logic [15:0] HDR_LEN = 16'(ICMP_HDR_LEN);

  logic            run;        // Frame in progress
  logic [15:0]     cnt;        // Index of the next beat to emit
  logic [7:0][7:0] hdr_q;      // Reply header, byte 7 goes out first
  ipv4_meta_t      meta_q;
  logic            last;

  logic            val_q;
  logic            sof_q;
  logic            eof_q;
  logic            pld_sel_q;  // Current beat comes from the buffer
  logic [7:0]      hdr_dat_q;

  assign last = (cnt == meta_q.pld_len - 16'd1);

  // The address runs one beat ahead of the output, which covers
  // the registered read of the buffer
  assign rd_addr = AW'(cnt - HDR_LEN);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      run       <= 1'b0;
      cnt       <= '0;
      val_q     <= 1'b0;
      sof_q     <= 1'b0;
      eof_q     <= 1'b0;
      pld_sel_q <= 1'b0;
    end else begin
      val_q     <= run;
      sof_q     <= run && (cnt == '0);
      eof_q     <= run && last;
      pld_sel_q <= run && (cnt >= HDR_LEN);
      if (run) begin
        cnt <= cnt + 16'd1;
        if (last) run <= 1'b0;
      end else if (start) begin
        run <= 1'b1;
        cnt <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!run && start) begin
      hdr_q  <= rsp.icmp;
      meta_q <= rsp.ipv4;      // Held until the next reply
    end
    hdr_dat_q <= hdr_q[3'd7 - cnt[2:0]];   // Big-endian header byte order
  end

  always_comb begin
    out_strm.dat = pld_sel_q ? rd_dat : hdr_dat_q;
    out_strm.val = val_q;
    out_strm.sof = sof_q;
    out_strm.eof = eof_q;
    out_strm.err = 1'b0;
    out_meta     = meta_q;
    done         = eof_q;       // Tells the control block the buffer is free
  end

endmodule : icmp_tx

// ==== design/icmp_echo_ctrl.sv ====
`timescale 1ns/100ps

module icmp_echo_ctrl (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                req_val,
  input  icmp_pkg::echo_req_t req,
  input  logic                done,
  output logic                busy,
  output logic                start,
  output icmp_pkg::echo_rsp_t rsp
);

  import icmp_pkg::*;

  logic [16:0] cks_sum;
  logic [15:0] cks_rep;
  logic        take;

  // Type 8 -> 0 drops the first header word by 0x0800,
  // so the stored complement grows by the same amount
  always_comb begin
    cks_sum = {1'b0, req.icmp.icmp_cks} + 17'h0_0800;
    cks_rep = cks_sum[15:0] + 16'(cks_sum[16]); // End-around carry
    take    = req_val && !busy;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      busy  <= 1'b0;
      start <= 1'b0;
    end else begin
      start <= take;
      if (done) busy <= 1'b0;     // Free one cycle after the last beat
      else if (take) busy <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rsp.ipv4.src_ip    <= req.ipv4.dst_ip; // Reply goes back to the sender
      rsp.ipv4.dst_ip    <= req.ipv4.src_ip;
      rsp.ipv4.proto     <= ICMP_PROTO;
      rsp.ipv4.pld_len   <= req.ipv4.pld_len;
      rsp.icmp.icmp_type <= TYPE_ECHO_REPLY;
      rsp.icmp.icmp_code <= req.icmp.icmp_code;
      rsp.icmp.icmp_cks  <= cks_rep;
      rsp.icmp.icmp_id   <= req.icmp.icmp_id;
      rsp.icmp.icmp_seq  <= req.icmp.icmp_seq;
    end
  end

endmodule : icmp_echo_ctrl

// ==== design/icmp_pld_buf.sv ====
`timescale 1ns/100ps

module icmp_pld_buf #(
  parameter int MAX_PLD = 64
) (
  input  logic                       clk,
  input  logic                       wr_en,
  input  logic [$clog2(MAX_PLD)-1:0] wr_addr,
  input  logic [7:0]                 wr_dat,
  input  logic [$clog2(MAX_PLD)-1:0] rd_addr,
  output logic [7:0]                 rd_dat
);

  // Holds the payload of the request currently being answered.
  // Readers only fetch offsets below the frame length, so stale
  // bytes from earlier frames never reach the output.
  logic [7:0] mem [0:MAX_PLD-1];

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_dat;
  end

  always_ff @(posedge clk) begin
    rd_dat <= mem[rd_addr]; // Data one cycle after the address
  end

endmodule : icmp_pld_buf

// ==== design/icmp_rx.sv ====
`timescale 1ns/100ps

module icmp_rx #(
  parameter int MAX_PLD = 64
) (
  input  logic                         clk,
  input  logic                         fsm_rst,
  input  logic                         busy,
  input  icmp_pkg::stream_t            in_strm,
  input  icmp_pkg::ipv4_meta_t         in_meta,
  output logic                         wr_en,
  output logic [$clog2(MAX_PLD)-1:0]   wr_addr,
  output logic [7:0]                   wr_dat,
  output logic                         req_val,
  output icmp_pkg::echo_req_t          req
);

  import icmp_pkg::*;

  localparam int          AW      = $clog2(MAX_PLD);
  localparam logic [15:0] HDR_LEN = 16'(ICMP_HDR_LEN);
  localparam logic [15:0] MAX_LEN = 16'(ICMP_HDR_LEN + MAX_PLD);

  logic            receiving;  // Inside an accepted frame
  logic            err_seen;   // Err beat seen since sof
  logic [15:0]     cnt;        // Bytes taken so far
  logic [7:0][7:0] hdr;        // Header shift register, first byte ends up in [7]
  ipv4_meta_t      meta_q;

  logic            sof_ok;
  logic            beat;
  logic [15:0]     idx;
  logic [7:0][7:0] hdr_nxt;
  ipv4_meta_t      cur_meta;
  logic            err_any;
  logic            len_ok;
  logic            hdr_ok;
  logic            frame_ok;

  always_comb begin
    // A frame is only taken if it is ICMP and the reply path is free
    sof_ok   = in_strm.val && in_strm.sof && (in_meta.proto == ICMP_PROTO) && !busy;
    beat     = in_strm.val && (sof_ok || (receiving && !in_strm.sof));
    idx      = in_strm.sof ? '0 : cnt;       // Byte index of this beat
    cur_meta = in_strm.sof ? in_meta : meta_q;
    hdr_nxt  = (idx < HDR_LEN) ? {hdr[6:0], in_strm.dat} : hdr;
    err_any  = in_strm.err || (!in_strm.sof && err_seen);

    // Evaluated on the eof beat, hdr_nxt already holds the last header byte
    len_ok   = (idx + 16'd1 == cur_meta.pld_len) &&
               (cur_meta.pld_len >= HDR_LEN) &&
               (cur_meta.pld_len <= MAX_LEN);
    hdr_ok   = (hdr_nxt[7] == TYPE_ECHO_REQ) && (hdr_nxt[6] == 8'h00);
    frame_ok = len_ok && hdr_ok && !err_any;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      receiving <= 1'b0;
      err_seen  <= 1'b0;
      cnt       <= '0;
      wr_en     <= 1'b0;
      req_val   <= 1'b0;
    end else begin
      req_val <= 1'b0;
      wr_en   <= 1'b0;
      if (in_strm.val && in_strm.sof) receiving <= sof_ok; // New sof restarts or drops
      if (beat) begin
        cnt      <= idx + 16'd1;
        err_seen <= err_any;
        wr_en    <= (idx >= HDR_LEN) && (idx < MAX_LEN); // Payload bytes only
        if (in_strm.eof) begin
          receiving <= 1'b0;
          req_val   <= frame_ok;   // Bad frames vanish here
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sof_ok) meta_q <= in_meta;
    if (beat) begin
      hdr     <= hdr_nxt;
      wr_addr <= AW'(idx - HDR_LEN); // Payload offset
      wr_dat  <= in_strm.dat;
    end
    if (beat && in_strm.eof) begin
      req.ipv4 <= cur_meta;
      req.icmp <= icmp_hdr_t'(hdr_nxt);
    end
  end

endmodule : icmp_rx

// ==== design/icmp_pkg.sv ====
package icmp_pkg;

  // IPv4 protocol number carried in the IP header
  localparam logic [7:0] ICMP_PROTO = 8'd1;

  // Fixed part of every ICMP message in bytes
  localparam int ICMP_HDR_LEN = 8;

  localparam logic [7:0] TYPE_ECHO_REQ   = 8'd8;
  localparam logic [7:0] TYPE_ECHO_REPLY = 8'd0;

  // One byte per beat, strobes qualify the byte
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;  // First byte of the frame
    logic       eof;  // Last byte of the frame
    logic       err;  // Frame is corrupt
  } stream_t;

  // Metadata from the IPv4 layer, stable from sof to eof
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [7:0]  proto;
    logic [15:0] pld_len;  // ICMP header plus payload bytes
  } ipv4_meta_t;

  // Field order follows the wire order, so a byte shift
  // register of 8 bytes casts straight onto this struct
  typedef struct packed {
    logic [7:0]  icmp_type;
    logic [7:0]  icmp_code;
    logic [15:0] icmp_cks;
    logic [15:0] icmp_id;
    logic [15:0] icmp_seq;
  } icmp_hdr_t;

  // Parsed echo request
  typedef struct packed {
    ipv4_meta_t ipv4;
    icmp_hdr_t  icmp;
  } echo_req_t;

  // Reply descriptor for the transmitter
  typedef struct packed {
    ipv4_meta_t ipv4;
    icmp_hdr_t  icmp;
  } echo_rsp_t;

endpackage : icmp_pkg
